/* compile.f */
+incdir+src
+incdir+tb
src/operand_pkg.sv
src/opcap_cfg_pkg.sv
src/phys_regfile.sv
src/read_port_select.sv
src/operand_validate.sv
src/operand_station.sv
src/opcap_cfg.sv
src/operand_capture_top.sv
tb/tb_operand_capture.sv

/* Makefile */
# Verilator build and run of the operand capture testbench

VERILATOR ?= verilator
TOP ?= tb_operand_capture
FLIST ?= compile.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Everything OK

SOURCES := $(wildcard src/*.sv src/*.svh tb/*.sv tb/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# The binary is rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass or fail comes from the pass line in the simulator output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_model.svh */
// Random source and register file model for the operand capture testbench
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ====================
// Random numbers
// ====================

// LFSR state, starts from the fixed seed
logic [31:0] lfsr_state = 32'h3efe_51ac;

// Next state of a right shifting Galois LFSR
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h8020_0003;
	else
		return s >> 1;
endfunction

// Take n random bits, one LFSR step per bit
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], lfsr_state[0]};
		lfsr_state = lfsr_next(lfsr_state);
	end
	return r;
endfunction

// ====================
// Register file model
// ====================

// Expected contents and ready bits of every physical register
value_t model_val [`OPCAP_NPREG];
logic model_rdy [`OPCAP_NPREG];

// After reset every register is ready and holds zero
function automatic void model_reset();
	for (int r = 0; r < `OPCAP_NPREG; r++) begin
		model_val[r] = '0;
		model_rdy[r] = 1'b1;
	end
endfunction

// A rename makes the register wait for its writeback
function automatic void model_alloc(input preg_t r);
	model_rdy[r] = 1'b0;
endfunction

function automatic void model_write(input preg_t r, input value_t value);
	model_val[r] = value;
	model_rdy[r] = 1'b1;
endfunction

`endif

/* tb/tb_operand_capture.sv */
// Testbench driving the operand capture stage against a register file model
`timescale 1ns/1ps
`default_nettype none

`include "opcap_consts.svh"

module tb_operand_capture;

	import operand_pkg::*;
	import opcap_cfg_pkg::*;

`include "tb_model.svh"

	localparam int NENTRY = `OPCAP_NENTRY;

	// Instruction counts of the three test phases
	localparam int N_READY = 40;
	localparam int N_PEND = 40;
	localparam int N_MIXED = 40;

	// The run ends after 200 instructions of 40 cycles each
	localparam int INSTR_BUDGET = 200;
	localparam int CYCLES_PER_INSTR = 40;
	localparam int MAX_CYCLES = INSTR_BUDGET * CYCLES_PER_INSTR;

	// Wide enough for the whole operand array
	typedef logic [127:0] cmp_t;

	logic clk;
	logic rst_i;
	wb_t wb_i;
	logic alloc_i;
	logic [`OPCAP_PRB-1:0] alloc_reg_i;
	logic load_i;
	opreg_vec_t load_regs_i;
	logic issue_i;
	cfg_req_t cfg_i;
	logic [31:0] cfg_rdata_o;
	operand_t [NENTRY-1:0] operands_o;
	logic ready_o;
	logic busy_o;

	// Issue pulses driven so far
	int issues;
	int cycles = 0;

	// Bypass state as last written to CFG_CTRL
	bit bypass_on;

	operand_capture_top operand_capture_top_i (
		.clk(clk),
		.rst_i(rst_i),
		.wb_i(wb_i),
		.alloc_i(alloc_i),
		.alloc_reg_i(alloc_reg_i),
		.load_i(load_i),
		.load_regs_i(load_regs_i),
		.issue_i(issue_i),
		.cfg_i(cfg_i),
		.cfg_rdata_o(cfg_rdata_o),
		.operands_o(operands_o),
		.ready_o(ready_o),
		.busy_o(busy_o)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT never finished the test", cycles);
			$display("Something failed");
			$fatal(1);
		end
	end

	task automatic compare(input cmp_t actual, input cmp_t expected, input string msg);
		if (actual !== expected) begin
			$display("Fail at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	// ====================
	// Bus drivers
	// ====================

	// Write one register back and rename it in the same cycle if it is still ready
	task automatic write_reg(input preg_t r, input value_t value, input bit expect_pending);
		@(posedge clk);
		wb_i <= '{we: 1'b1, preg: r, val: value};
		alloc_i <= model_rdy[r];
		alloc_reg_i <= r;
		model_write(r, value);
		@(negedge clk);
		// The DUT has not seen this write yet
		if (expect_pending)
			compare(cmp_t'(ready_o), cmp_t'(0), "ready before the last writeback");
		@(posedge clk);
		wb_i.we <= 1'b0;
		alloc_i <= 1'b0;
	endtask

	task automatic alloc_preg(input preg_t r);
		@(posedge clk);
		alloc_i <= 1'b1;
		alloc_reg_i <= r;
		model_alloc(r);
		@(posedge clk);
		alloc_i <= 1'b0;
	endtask

	task automatic load_instr(input opreg_vec_t regs);
		@(posedge clk);
		load_i <= 1'b1;
		load_regs_i <= regs;
		@(posedge clk);
		load_i <= 1'b0;
	endtask

	task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
		@(posedge clk);
		cfg_i <= '{we: 1'b1, addr: addr, wdata: data};
		@(posedge clk);
		cfg_i.we <= 1'b0;
	endtask

	// Read data is combinational and settles before the falling edge
	task automatic cfg_read(input logic [1:0] addr, output logic [31:0] data);
		@(posedge clk);
		cfg_i.addr <= addr;
		@(negedge clk);
		data = cfg_rdata_o;
	endtask

	// ====================
	// Instruction flows
	// ====================

	function automatic opreg_vec_t pick_regs();
		opreg_vec_t regs;
		for (int n = 0; n < NENTRY; n++) begin
			regs[n] = preg_t'(rand_bits(`OPCAP_PRB));
		end
		// Some instructions name one register in two slots
		if (rand_bits(2) == 0)
			regs[NENTRY-1] = regs[0];
		return regs;
	endfunction

	task automatic wait_ready();
		@(negedge clk);
		while (!ready_o)
			@(negedge clk);
	endtask

	task automatic check_operands(input opreg_vec_t regs);
		for (int n = 0; n < NENTRY; n++) begin
			compare(cmp_t'(operands_o[n].aRn), cmp_t'(regs[n]),
				$sformatf("slot %0d register number", n));
			compare(cmp_t'(operands_o[n].v), cmp_t'(1), $sformatf("slot %0d valid", n));
			compare(cmp_t'(operands_o[n].val), cmp_t'(model_val[regs[n]]),
				$sformatf("slot %0d value of register %0d", n, regs[n]));
		end
	endtask

	// Hold the ready instruction for a random time and then issue it
	task automatic hold_and_issue();
		operand_t [NENTRY-1:0] snap;
		snap = operands_o;
		repeat (int'(rand_bits(3))) begin
			@(negedge clk);
			compare(cmp_t'(operands_o), cmp_t'(snap), "operands moved while waiting for issue");
			compare(cmp_t'(ready_o), cmp_t'(1), "ready dropped before issue");
		end
		@(posedge clk);
		issue_i <= 1'b1;
		@(posedge clk);
		issue_i <= 1'b0;
		issues++;
		@(negedge clk);
		compare(cmp_t'(busy_o), cmp_t'(0), "busy after issue");
		compare(cmp_t'(ready_o), cmp_t'(0), "ready after issue");
	endtask

	// All sources are ready and one of them is sometimes freshly written
	task automatic run_ready();
		opreg_vec_t regs;
		int slot;
		regs = pick_regs();
		slot = int'(rand_bits(1));
		if (rand_bits(1) == 1)
			write_reg(regs[slot], rand_bits(`OPCAP_DW), 1'b0);
		load_instr(regs);
		wait_ready();
		check_operands(regs);
		hold_and_issue();
	endtask

	// Sources renamed before the load and written back afterwards in random order
	task automatic run_pending();
		opreg_vec_t regs;
		preg_t pend[$];
		preg_t r;
		int idx;
		bit seen;
		regs = pick_regs();
		for (int n = 0; n < NENTRY; n++) begin
			seen = 1'b0;
			foreach (pend[k]) begin
				if (pend[k] == regs[n])
					seen = 1'b1;
			end
			if (!seen) begin
				pend.push_back(regs[n]);
				alloc_preg(regs[n]);
			end
		end
		load_instr(regs);
		while (pend.size() > 0) begin
			idx = int'(rand_bits(2)) % pend.size();
			r = pend[idx];
			pend.delete(idx);
			repeat (int'(rand_bits(2))) begin
				@(negedge clk);
				compare(cmp_t'(ready_o), cmp_t'(0), "ready while writebacks are pending");
			end
			write_reg(r, rand_bits(`OPCAP_DW), 1'b1);
		end
		// The bypass captures the last operand on the edge of its own writeback
		// Without it the register file read adds one more edge
		@(negedge clk);
		compare(cmp_t'(ready_o), cmp_t'(bypass_on),
			"ready right after the edge of the last writeback");
		wait_ready();
		check_operands(regs);
		hold_and_issue();
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		logic [31:0] rdata;
		logic [31:0] wdata;
		clk = 1'b0;
		rst_i = 1'b1;
		wb_i = '0;
		alloc_i = 1'b0;
		alloc_reg_i = '0;
		load_i = 1'b0;
		load_regs_i = '0;
		issue_i = 1'b0;
		cfg_i = '0;
		issues = 0;
		bypass_on = 1'b1;
		model_reset();
		repeat (10) @(posedge clk);
		rst_i <= 1'b0;

		cfg_read(CFG_CTRL, rdata);
		compare(cmp_t'(rdata), cmp_t'(1), "bypass enable after reset");

		// Every register gets a random value before the first load
		for (int r = 0; r < `OPCAP_NPREG; r++) begin
			write_reg(preg_t'(r), rand_bits(`OPCAP_DW), 1'b0);
		end

		repeat (N_READY) run_ready();
		repeat (N_PEND) run_pending();

		// Only bit 0 of the control word is kept
		wdata = rand_bits(32) & ~32'h1;
		cfg_write(CFG_CTRL, wdata);
		bypass_on = wdata[0];
		cfg_read(CFG_CTRL, rdata);
		compare(cmp_t'(rdata), cmp_t'(wdata & 32'h1), "control word after clearing bypass");

		repeat (N_MIXED) begin
			if (rand_bits(1) == 1)
				run_pending();
			else
				run_ready();
		end

		cfg_read(CFG_ISSUE_CNT, rdata);
		compare(cmp_t'(rdata), cmp_t'(issues), "issue counter");
		cfg_write(CFG_ISSUE_CNT, rand_bits(32));
		cfg_read(CFG_ISSUE_CNT, rdata);
		compare(cmp_t'(rdata), cmp_t'(issues), "issue counter after a write to it");

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* src/operand_capture_top.sv */
// Operand capture stage joining station, port selector, register file and validator
`timescale 1ns/1ps
`default_nettype none

`include "opcap_consts.svh"

module operand_capture_top (
	input wire logic clk,
	input wire logic rst_i,
	input wire operand_pkg::wb_t wb_i,
	input wire logic alloc_i,
	input wire logic [`OPCAP_PRB-1:0] alloc_reg_i,
	input wire logic load_i,
	input wire operand_pkg::opreg_vec_t load_regs_i,
	input wire logic issue_i,
	input wire opcap_cfg_pkg::cfg_req_t cfg_i,
	output logic [31:0] cfg_rdata_o,
	output operand_pkg::operand_t [`OPCAP_NENTRY-1:0] operands_o,
	output logic ready_o,
	output logic busy_o
);

	import operand_pkg::*;

	// ====================
	// Internal wiring
	// ====================

	logic [`OPCAP_NREG_RPORTS-1:0] rd_en;
	preg_t [`OPCAP_NREG_RPORTS-1:0] rd_addr;
	operand_t [`OPCAP_NREG_RPORTS-1:0] rf_oper;
	operand_t [`OPCAP_NENTRY-1:0] upd;
	operand_t [`OPCAP_NBPI-1:0] wb_bypass;
	logic bypass_en;

	// The writeback bus seen as an operand, valid whenever it writes
	assign wb_bypass = {`OPCAP_NBPI{operand_t'{aRn: wb_i.preg, val: wb_i.val, v: wb_i.we}}};

	// The station's slots are the operands presented to issue
	operand_station operand_station_i (
		.clk(clk),
		.rst_i(rst_i),
		.load_i(load_i),
		.load_regs_i(load_regs_i),
		.issue_i(issue_i),
		.upd_i(upd),
		.slots_o(operands_o),
		.busy_o(busy_o),
		.ready_o(ready_o)
	);

	read_port_select read_port_select_i (
		.clk(clk),
		.rst_i(rst_i),
		.slots_i(operands_o),
		.busy_i(busy_o),
		.rd_en_o(rd_en),
		.rd_addr_o(rd_addr)
	);

	phys_regfile phys_regfile_i (
		.clk(clk),
		.rst_i(rst_i),
		.wb_i(wb_i),
		.alloc_i(alloc_i),
		.alloc_reg_i(alloc_reg_i),
		.rd_en_i(rd_en),
		.rd_addr_i(rd_addr),
		.rd_oper_o(rf_oper)
	);

	operand_validate #(
		.NENTRY(`OPCAP_NENTRY),
		.NBPI(`OPCAP_NBPI)
	) operand_validate_i (
		.rf_oper_i(rf_oper),
		.oper_i(operands_o),
		.bypass_i(wb_bypass),
		.bypass_en_i(bypass_en),
		.oper_o(upd)
	);

	opcap_cfg opcap_cfg_i (
		.clk(clk),
		.rst_i(rst_i),
		.cfg_i(cfg_i),
		.cfg_rdata_o(cfg_rdata_o),
		.issue_i(issue_i),
		.bypass_en_o(bypass_en)
	);

endmodule

`default_nettype wire

/* src/opcap_cfg.sv */
// Configuration registers holding the bypass enable and the issue counter
`timescale 1ns/1ps
`default_nettype none

module opcap_cfg (
	input wire logic clk,
	input wire logic rst_i,
	input wire opcap_cfg_pkg::cfg_req_t cfg_i,
	output logic [31:0] cfg_rdata_o,
	input wire logic issue_i,
	output logic bypass_en_o
);

	import opcap_cfg_pkg::*;

	// Number of instructions issued since reset
	logic [31:0] issue_cnt_q;

	// ====================
	// Register writes
	// ====================

	// Only the bypass bit of CFG_CTRL is implemented
	// Writes to the counter address have no effect
	always_ff @(posedge clk) begin
		if (rst_i) begin
			bypass_en_o <= CTRL_BYPASS_RST;
			issue_cnt_q <= '0;
		end else begin
			if (cfg_i.we && cfg_i.addr == CFG_CTRL)
				bypass_en_o <= cfg_i.wdata[CTRL_BYPASS_BIT];
			if (issue_i)
				issue_cnt_q <= issue_cnt_q + 32'd1;
		end
	end

	// Read data follows the address without a clock edge
	always_comb begin
		cfg_rdata_o = '0;
		case (cfg_i.addr)
			CFG_CTRL: cfg_rdata_o[CTRL_BYPASS_BIT] = bypass_en_o;
			CFG_ISSUE_CNT: cfg_rdata_o = issue_cnt_q;
			default: cfg_rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/operand_station.sv */
// Operand station holding one instruction's sources until all are captured
`timescale 1ns/1ps
`default_nettype none

`include "opcap_consts.svh"

module operand_station (
	input wire logic clk,
	input wire logic rst_i,
	input wire logic load_i,
	input wire operand_pkg::opreg_vec_t load_regs_i,
	input wire logic issue_i,
	input wire operand_pkg::operand_t [`OPCAP_NENTRY-1:0] upd_i,
	output operand_pkg::operand_t [`OPCAP_NENTRY-1:0] slots_o,
	output logic busy_o,
	output logic ready_o
);

	import operand_pkg::*;

	localparam int NENTRY = `OPCAP_NENTRY;

	// Slot contents after this cycle's captures
	operand_t [NENTRY-1:0] nxt_slots;
	logic [NENTRY-1:0] nxt_v;

	// Only a slot still waiting takes the validator output
	// Slots already captured stay untouched, which keeps them stable
	// while the instruction waits for issue
	always_comb begin
		nxt_slots = slots_o;
		for (int n = 0; n < NENTRY; n++) begin
			if (!slots_o[n].v && upd_i[n].v)
				nxt_slots[n] = upd_i[n];
			nxt_v[n] = nxt_slots[n].v;
		end
	end

	// ====================
	// Station state
	// ====================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			busy_o <= 1'b0;
			ready_o <= 1'b0;
			for (int n = 0; n < NENTRY; n++) begin
				slots_o[n].v <= 1'b0;
			end
		end else if (load_i && !busy_o) begin
			// New instruction, every source starts out pending
			busy_o <= 1'b1;
			ready_o <= 1'b0;
			for (int n = 0; n < NENTRY; n++) begin
				slots_o[n].aRn <= load_regs_i[n];
				slots_o[n].val <= VALUE_ZERO;
				slots_o[n].v <= 1'b0;
			end
		end else if (issue_i && ready_o) begin
			// Issue empties the station
			busy_o <= 1'b0;
			ready_o <= 1'b0;
			for (int n = 0; n < NENTRY; n++) begin
				slots_o[n].v <= 1'b0;
			end
		end else if (busy_o) begin
			slots_o <= nxt_slots;
			// Ready rises on the same edge as the last capture
			ready_o <= &nxt_v;
		end
	end

	// A new instruction arrives only into an empty station
	a_load_not_busy: assert property (@(posedge clk) disable iff (rst_i)
		load_i |-> !busy_o);

	// Issue is only signalled once every operand is held
	a_issue_when_ready: assert property (@(posedge clk) disable iff (rst_i)
		issue_i |-> ready_o);

endmodule

`default_nettype wire

/* src/operand_validate.sv */
// Operand validation from register file read ports and the writeback bypass
`timescale 1ns/1ps
`default_nettype none

`include "opcap_consts.svh"

module operand_validate #(
	parameter int NENTRY = `OPCAP_NENTRY,
	parameter int NBPI = `OPCAP_NBPI
) (
	input wire operand_pkg::operand_t [`OPCAP_NREG_RPORTS-1:0] rf_oper_i,
	input wire operand_pkg::operand_t [NENTRY-1:0] oper_i,
	input wire operand_pkg::operand_t [NBPI-1:0] bypass_i,
	input wire logic bypass_en_i,
	output operand_pkg::operand_t [NENTRY-1:0] oper_o
);

	import operand_pkg::*;

	localparam int NREG_RPORTS = `OPCAP_NREG_RPORTS;

	always_comb begin
		// ====================
		// Register file results
		// ====================
		for (int nn = 0; nn < NENTRY; nn++) begin
			// Start from the slot itself with no value attached
			oper_o[nn] = oper_i[nn];
			oper_o[nn].val = VALUE_ZERO;
			for (int jj = 0; jj < NREG_RPORTS; jj++) begin
				// A ready port reading the same register resolves the operand
				if (oper_i[nn].aRn == rf_oper_i[jj].aRn && rf_oper_i[jj].v &&
					!oper_i[nn].v) begin
					oper_o[nn].val = rf_oper_i[jj].val;
					oper_o[nn].v = 1'b1;
				end
			end
		end

		// ====================
		// Writeback bypass
		// ====================

		// Taking the value straight off the writeback bus saves the cycle
		// spent in the register file
		// Both sources carry the same value so the later one simply wins
		if (bypass_en_i) begin
			for (int nn = 0; nn < NENTRY; nn++) begin
				for (int jj = 0; jj < NBPI; jj++) begin
					if (oper_i[nn].aRn == bypass_i[jj].aRn && bypass_i[jj].v &&
						!oper_i[nn].v) begin
						oper_o[nn].val = bypass_i[jj].val;
						oper_o[nn].v = 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/read_port_select.sv */
// Round-robin assignment of pending operand registers to the read ports
`timescale 1ns/1ps
`default_nettype none

`include "opcap_consts.svh"

module read_port_select (
	input wire logic clk,
	input wire logic rst_i,
	input wire operand_pkg::operand_t [`OPCAP_NENTRY-1:0] slots_i,
	input wire logic busy_i,
	output logic [`OPCAP_NREG_RPORTS-1:0] rd_en_o,
	output operand_pkg::preg_t [`OPCAP_NREG_RPORTS-1:0] rd_addr_o
);

	localparam int NENTRY = `OPCAP_NENTRY;
	localparam int NREG_RPORTS = `OPCAP_NREG_RPORTS;
	localparam int PW = (NENTRY > 1) ? $clog2(NENTRY) : 1;

	// Slot where the next scan starts
	logic [PW-1:0] ptr_q;

	// Last slot granted during this cycle's scan
	int last;

	// Walk the slots from the pointer and grant each invalid one a port
	// A register already granted this cycle is not read twice
	always_comb begin
		int idx;
		int nport;
		logic dup;
		rd_en_o = '0;
		rd_addr_o = '0;
		nport = 0;
		last = int'(ptr_q);
		for (int k = 0; k < NENTRY; k++) begin
			idx = int'(ptr_q) + k;
			if (idx >= NENTRY)
				idx = idx - NENTRY;
			dup = 1'b0;
			for (int p = 0; p < NREG_RPORTS; p++) begin
				if (p < nport && rd_addr_o[p] == slots_i[idx].aRn)
					dup = 1'b1;
			end
			if (busy_i && !slots_i[idx].v && !dup && nport < NREG_RPORTS) begin
				rd_en_o[nport] = 1'b1;
				rd_addr_o[nport] = slots_i[idx].aRn;
				nport = nport + 1;
				last = idx;
			end
		end
	end

	// Move the pointer past the last granted slot so others get a turn
	always_ff @(posedge clk) begin
		if (rst_i)
			ptr_q <= '0;
		else if (|rd_en_o)
			ptr_q <= (last == NENTRY - 1) ? '0 : PW'(last + 1);
	end

endmodule

`default_nettype wire

/* src/phys_regfile.sv */
// Physical register file with ready bits, one write port and registered reads
`timescale 1ns/1ps
`default_nettype none

`include "opcap_consts.svh"

module phys_regfile (
	input wire logic clk,
	input wire logic rst_i,
	input wire operand_pkg::wb_t wb_i,
	input wire logic alloc_i,
	input wire logic [`OPCAP_PRB-1:0] alloc_reg_i,
	input wire logic [`OPCAP_NREG_RPORTS-1:0] rd_en_i,
	input wire operand_pkg::preg_t [`OPCAP_NREG_RPORTS-1:0] rd_addr_i,
	output operand_pkg::operand_t [`OPCAP_NREG_RPORTS-1:0] rd_oper_o
);

	import operand_pkg::*;

	localparam int NREG_RPORTS = `OPCAP_NREG_RPORTS;
	localparam int NPREG = `OPCAP_NPREG;

	// Register contents and one ready bit per register
	value_t regs_q [NPREG];
	logic [NPREG-1:0] rdy_q;

	// ====================
	// Write and rename
	// ====================

	// A rename clears the ready bit until the register is written back
	// The write comes second so that an alloc and a write to the same
	// register in one cycle leave it ready
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 0; i < NPREG; i++) begin
				regs_q[i] <= '0;
			end
			rdy_q <= '1;
		end else begin
			if (alloc_i)
				rdy_q[alloc_reg_i] <= 1'b0;
			if (wb_i.we) begin
				regs_q[wb_i.preg] <= wb_i.val;
				rdy_q[wb_i.preg] <= 1'b1;
			end
		end
	end

	// ====================
	// Read ports
	// ====================

	// Reads are registered and see a same cycle write or rename first
	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int p = 0; p < NREG_RPORTS; p++) begin
				rd_oper_o[p].v <= 1'b0;
			end
		end else begin
			for (int p = 0; p < NREG_RPORTS; p++) begin
				rd_oper_o[p].aRn <= rd_addr_i[p];
				if (!rd_en_i[p]) begin
					// An idle port returns nothing usable
					rd_oper_o[p].v <= 1'b0;
				end else if (wb_i.we && wb_i.preg == rd_addr_i[p]) begin
					rd_oper_o[p].val <= wb_i.val;
					rd_oper_o[p].v <= 1'b1;
				end else begin
					rd_oper_o[p].val <= regs_q[rd_addr_i[p]];
					rd_oper_o[p].v <= rdy_q[rd_addr_i[p]] &&
						!(alloc_i && alloc_reg_i == rd_addr_i[p]);
				end
			end
		end
	end

	// Writeback only targets a register renamed earlier or in the same cycle
	a_write_after_alloc: assert property (@(posedge clk) disable iff (rst_i)
		wb_i.we |-> !rdy_q[wb_i.preg] || (alloc_i && alloc_reg_i == wb_i.preg));

endmodule

`default_nettype wire

/* src/opcap_cfg_pkg.sv */
// Configuration bus types and register map of the operand capture stage
`default_nettype none

package opcap_cfg_pkg;

	// Configuration bus request, a write happens when we is set
	typedef struct packed {
		logic we;
		logic [1:0] addr;
		logic [31:0] wdata;
	} cfg_req_t;

	// ====================
	// Register map
	// ====================

	// Control register, bit 0 enables the writeback bypass
	localparam logic [1:0] CFG_CTRL = 2'd0;

	// Count of issued instructions, read only
	localparam logic [1:0] CFG_ISSUE_CNT = 2'd1;

	// Bit position of the bypass enable in CFG_CTRL
	localparam int CTRL_BYPASS_BIT = 0;

	// The bypass comes out of reset switched on
	localparam logic CTRL_BYPASS_RST = 1'b1;

endpackage

`default_nettype wire

/* src/operand_pkg.sv */
// Operand and writeback types for the operand capture datapath
`default_nettype none

package operand_pkg;

`include "opcap_consts.svh"

	// Physical register number
	typedef logic [`OPCAP_PRB-1:0] preg_t;

	// One operand value
	typedef logic [`OPCAP_DW-1:0] value_t;

	// An operand as it travels between station, validator and register file
	// The valid bit says the value field holds the register contents
	typedef struct packed {
		preg_t aRn;
		value_t val;
		logic v;
	} operand_t;

	// Writeback bus into the register file write port
	typedef struct packed {
		logic we;
		preg_t preg;
		value_t val;
	} wb_t;

	// Source register numbers of an instruction being loaded
	typedef preg_t [`OPCAP_NENTRY-1:0] opreg_vec_t;

	// Value placed on operands that could not be resolved this cycle
	localparam value_t VALUE_ZERO = '0;

endpackage

`default_nettype wire

/* src/opcap_consts.svh */
// Width and count constants shared by the operand capture stage
`ifndef OPCAP_CONSTS_SVH
`define OPCAP_CONSTS_SVH

// ====================
// Datapath widths
// ====================

// Width of one operand value
`define OPCAP_DW 32

// Number of physical registers and the bits needed to name one
`define OPCAP_NPREG 64
`define OPCAP_PRB 6

// ====================
// Port and entry counts
// ====================

// Register file read ports shared by all operands of the station
`define OPCAP_NREG_RPORTS 2

// Source operands carried by one instruction
`define OPCAP_NENTRY 3

// Bypass inputs into the validator, only the writeback bus here
`define OPCAP_NBPI 1

`endif
